//--- hdl/cvtor_settings.svh
`ifndef CVTOR_SETTINGS_SVH
`define CVTOR_SETTINGS_SVH

// ====================
// stream word geometry
// ====================
`define CVTOR_WORD_BYTES 8 // bytes per 64-bit stream word

// ====================
// memory sizes
// ====================
`define CVTOR_BANK_WORDS 64 // per store bank, one bank per channel group
`define CVTOR_SORT_WORDS 128 // max ch parts x 2 banks x 8 bytes x col parts

// ====================
// gather shape
// ====================
`define CVTOR_COL_PARTS 4 // column words gathered per channel row
`define CVTOR_MAX_CH_PARTS 2 // legal ch_part_num is 1 .. this

// byte reversal at input and output
// software loads little endian words, the gather works on big endian
// set to 0 to pass words through unswapped
`define CVTOR_ENDIAN_SWAP 1

`endif

//--- hdl/cvtor_pkg.sv
`default_nettype none

`include "cvtor_settings.svh"

package cvtor_pkg;

	// one stream or memory word, byte 0 sits in the top 8 bits
	typedef logic [`CVTOR_WORD_BYTES*8-1:0] word_t;

	// first word of a frame
	typedef struct packed {
		logic [15:0] ch_step; // words between channels of one column
		logic [15:0] chpart_step; // words between channel parts
		logic [7:0]  ch_part_num; // 1 .. max ch parts
	} cfg_t;

	// single-port memory access
	typedef struct packed {
		logic                         en;
		logic [`CVTOR_WORD_BYTES-1:0] we_mask; // bit i writes wdata[8*i +: 8]
		logic [7:0]                   addr;
		word_t                        wdata;
	} mem_req_t;

	// output beat
	typedef struct packed {
		word_t data;
		logic  last; // final beat of the frame
	} stream_t;

	// reverse byte order of a word
	function automatic word_t swap_bytes(input word_t w);
		word_t r;
		for (int i = 0; i < `CVTOR_WORD_BYTES; i++) begin
			r[8*i +: 8] = w[8*(`CVTOR_WORD_BYTES-1-i) +: 8];
		end
		return r;
	endfunction

endpackage

`default_nettype wire

//--- hdl/sram_bytewise.sv
`timescale 1ns/10ps
`default_nettype none

`include "cvtor_settings.svh"

module sram_bytewise import cvtor_pkg::*; #(
	parameter int DEPTH = 64
) (
	input  wire           clk,
	input  wire mem_req_t req,
	output word_t         q
);

	localparam int AW = $clog2(DEPTH); // low address bits in use

	word_t mem [DEPTH];

	// read-first, one cycle latency, masked byte writes
	always_ff @(posedge clk) begin
		if (req.en) begin
			for (int i = 0; i < `CVTOR_WORD_BYTES; i++) begin
				if (req.we_mask[i]) begin
					mem[req.addr[AW-1:0]][8*i +: 8] <= req.wdata[8*i +: 8];
				end
			end
			q <= mem[req.addr[AW-1:0]]; // old word, before this write
		end
	end

endmodule

`default_nettype wire

//--- hdl/phase_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "cvtor_settings.svh"

module phase_ctrl import cvtor_pkg::*; (
	input  wire            clk,
	input  wire            reset,
	input  wire word_t     in_data,
	input  wire            in_valid,
	output logic           in_read,
	output cfg_t           cfg,
	input  wire mem_req_t  sort_rd,
	output mem_req_t [1:0] bank_req,
	output logic           sort_start,
	input  wire            sort_done,
	output logic           out_start,
	input  wire            out_done,
	output logic           out_phase
);

	localparam int SAW = $clog2(`CVTOR_BANK_WORDS);

	typedef enum logic [2:0] {
		IDLE,
		CFG_READ,
		STORE,
		SORT,
		OUTPUT
	} state_t;

	state_t         state;
	state_t         state_nx;
	word_t          in_word; // after optional byte reversal
	logic           take; // word accepted this cycle
	logic [SAW-1:0] st_addr;
	logic           st_bank; // 0 = bank0, 1 = bank1
	logic           st_last; // 128th store word

	assign in_word = (`CVTOR_ENDIAN_SWAP != 0) ? swap_bytes(in_data) : in_data;

	// source is read only while config or store is open
	assign in_read = in_valid && (state == CFG_READ || state == STORE);
	assign take = in_valid && in_read;
	assign st_last = take && (state == STORE) && st_bank &&
		(st_addr == SAW'(`CVTOR_BANK_WORDS - 1));
	assign out_phase = (state == OUTPUT); // sort memory goes to stream_out

	// ====================
	// FSM
	// ====================
	always_comb begin
		state_nx = state;
		case (state)
			IDLE:     if (in_valid) state_nx = CFG_READ; // frame begins
			CFG_READ: if (take) state_nx = STORE; // single config word
			STORE:    if (st_last) state_nx = SORT;
			SORT:     if (sort_done) state_nx = OUTPUT;
			OUTPUT:   if (out_done) state_nx = IDLE; // counters already wrapped
			default:  state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			sort_start <= 1'b0;
			out_start <= 1'b0;
		end else begin
			state <= state_nx;
			sort_start <= st_last; // cycle after the last store word
			out_start <= sort_done && (state == SORT);
		end
	end

	// config capture, fields from the low 40 bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cfg <= '0;
		end else if (take && state == CFG_READ) begin
			cfg.ch_step <= in_word[15:0];
			cfg.chpart_step <= in_word[31:16];
			cfg.ch_part_num <= in_word[39:32];
		end
	end

	// ====================
	// store addressing
	// ====================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			st_addr <= '0;
			st_bank <= 1'b0;
		end else if (take && state == STORE) begin
			if (st_addr == SAW'(`CVTOR_BANK_WORDS - 1)) begin
				st_addr <= '0;
				st_bank <= ~st_bank; // back to bank0 after bank1 fills
			end else begin
				st_addr <= st_addr + 1'b1;
			end
		end
	end

	// bank port steering, store writes or sort reads
	always_comb begin
		bank_req = '0;
		for (int b = 0; b < 2; b++) begin
			if (state == STORE) begin
				bank_req[b].en = take && (st_bank == 1'(b));
				bank_req[b].we_mask = '1; // full word
				bank_req[b].addr = 8'(st_addr);
				bank_req[b].wdata = in_word;
			end else if (state == SORT) begin
				bank_req[b] = sort_rd; // both banks read, engine picks one
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/sort_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "cvtor_settings.svh"

module sort_engine import cvtor_pkg::*; (
	input  wire           clk,
	input  wire           reset,
	input  wire cfg_t     cfg,
	input  wire           sort_start,
	output mem_req_t      bank_rd,
	input  wire word_t    bank0_q,
	input  wire word_t    bank1_q,
	output mem_req_t      sort_req,
	output logic          sort_done
);

	localparam int LW = $clog2(`CVTOR_WORD_BYTES); // lane / byte index width
	localparam int CPW = $clog2(`CVTOR_COL_PARTS);

	logic           running;
	logic [LW-1:0]  ch_sel; // output lane k, fastest
	logic [7:0]     ch_part; // p
	logic           bank_sel; // b
	logic [LW-1:0]  byte_sel; // t
	logic [CPW-1:0] col_part; // c, slowest
	logic           sel_wrap;
	logic           part_wrap;
	logic           bank_wrap;
	logic           byte_wrap;
	logic           col_wrap;
	logic [15:0]    rd_addr;
	logic           vld_d1;
	logic           last_d1;
	logic           bank_d1;
	logic [LW-1:0]  byte_d1;
	logic [LW-1:0]  lane_d1;
	word_t          bank_word;
	logic [7:0]     pick;
	logic           vld_d2;
	logic           last_d2;
	logic [LW-1:0]  lane_d2;
	logic [7:0]     gbyte; // gathered byte, written next cycle
	logic [7:0]     sort_addr;

	// ====================
	// nested counters
	// ====================
	assign sel_wrap = (ch_sel == '1);
	assign part_wrap = sel_wrap && (ch_part == cfg.ch_part_num - 8'd1);
	assign bank_wrap = part_wrap && bank_sel;
	assign byte_wrap = bank_wrap && (byte_sel == '1);
	assign col_wrap = byte_wrap && (col_part == CPW'(`CVTOR_COL_PARTS - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			ch_sel <= '0;
			ch_part <= '0;
			bank_sel <= 1'b0;
			byte_sel <= '0;
			col_part <= '0;
		end else if (running) begin
			ch_sel <= ch_sel + 1'b1; // 7 -> 0 by width
			if (sel_wrap) ch_part <= part_wrap ? 8'd0 : ch_part + 8'd1;
			if (part_wrap) bank_sel <= ~bank_sel;
			if (bank_wrap) byte_sel <= byte_sel + 1'b1;
			if (byte_wrap) col_part <= col_wrap ? '0 : col_part + 1'b1;
			if (col_wrap) running <= 1'b0; // all counters are back at 0
		end else if (sort_start) begin
			running <= 1'b1;
		end
	end

	// k * ch_step + p * chpart_step + c
	assign rd_addr = 16'(ch_sel) * cfg.ch_step + 16'(ch_part) * cfg.chpart_step +
		16'(col_part);

	always_comb begin
		bank_rd = '0;
		bank_rd.en = running; // one read per cycle
		bank_rd.addr = rd_addr[7:0];
	end

	// ====================
	// gather pipeline
	// ====================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			vld_d1 <= 1'b0;
			last_d1 <= 1'b0;
			vld_d2 <= 1'b0;
			last_d2 <= 1'b0;
		end else begin
			vld_d1 <= running; // bank word arrives with this stage
			last_d1 <= running && col_wrap;
			vld_d2 <= vld_d1;
			last_d2 <= last_d1;
		end
	end

	// selectors ride along with the read
	always_ff @(posedge clk) begin
		bank_d1 <= bank_sel;
		byte_d1 <= byte_sel;
		lane_d1 <= ch_sel;
		lane_d2 <= lane_d1;
		gbyte <= pick;
	end

	assign bank_word = bank_d1 ? bank1_q : bank0_q;
	assign pick = bank_word[8*(`CVTOR_WORD_BYTES-1-int'(byte_d1)) +: 8]; // byte t, MSB first

	// sort word address, steps after lane 7
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sort_addr <= '0;
		end else if (vld_d2 && lane_d2 == '1) begin
			sort_addr <= last_d2 ? 8'd0 : sort_addr + 8'd1;
		end
	end

	// byte replicated over the word, mask keeps lane k only
	always_comb begin
		sort_req = '0;
		sort_req.en = vld_d2;
		sort_req.we_mask[`CVTOR_WORD_BYTES-1-int'(lane_d2)] = vld_d2;
		sort_req.addr = sort_addr;
		sort_req.wdata = {`CVTOR_WORD_BYTES{gbyte}};
	end

	assign sort_done = vld_d2 && last_d2; // with the final write

endmodule

`default_nettype wire

//--- hdl/stream_out.sv
`timescale 1ns/10ps
`default_nettype none

`include "cvtor_settings.svh"

module stream_out import cvtor_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        out_start,
	input  wire cfg_t  cfg,
	output mem_req_t   sort_rd,
	input  wire word_t sort_q,
	output stream_t    out_beat,
	output logic       out_valid,
	output logic       out_done
);

	// words per channel part, 2 banks x bytes x col parts
	localparam int PART_WORDS = 2 * `CVTOR_WORD_BYTES * `CVTOR_COL_PARTS;

	logic        running;
	logic        active; // read issued this cycle
	logic        rd_last;
	logic        last_q; // aligned with the read latency
	logic [7:0]  rd_addr;
	logic [15:0] beat_num; // N

	assign beat_num = 16'(cfg.ch_part_num) * 16'(PART_WORDS);
	assign active = out_start || running; // first read with out_start
	assign rd_last = (16'(rd_addr) == beat_num - 16'd1);

	always_comb begin
		sort_rd = '0;
		sort_rd.en = active;
		sort_rd.addr = rd_addr;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			rd_addr <= '0;
			out_valid <= 1'b0;
			last_q <= 1'b0;
		end else begin
			out_valid <= active; // beat one cycle after its read
			last_q <= active && rd_last;
			if (active) begin
				if (rd_last) begin
					running <= 1'b0;
					rd_addr <= '0; // ready for the next frame
				end else begin
					running <= 1'b1;
					rd_addr <= rd_addr + 8'd1;
				end
			end
		end
	end

	always_comb begin
		out_beat.data = (`CVTOR_ENDIAN_SWAP != 0) ? swap_bytes(sort_q) : sort_q;
		out_beat.last = last_q;
	end

	assign out_done = out_valid && last_q;

endmodule

`default_nettype wire

//--- hdl/cvtor_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cvtor_settings.svh"

module cvtor_top import cvtor_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire word_t in_data,
	input  wire        in_valid,
	output logic       in_read,
	output stream_t    out_beat,
	output logic       out_valid
);

	cfg_t           cfg;
	mem_req_t [1:0] bank_req; // from phase_ctrl, store or sort
	mem_req_t       bank_rd; // sort engine reads
	mem_req_t       sort_wr; // sort engine byte writes
	mem_req_t       out_rd; // output reads
	mem_req_t       sort_mem_req;
	word_t          bank0_q;
	word_t          bank1_q;
	word_t          sort_q;
	logic           sort_start;
	logic           sort_done;
	logic           out_start;
	logic           out_done;
	logic           out_phase;

	phase_ctrl u_phase_ctrl (
		.clk        (clk),
		.reset      (reset),
		.in_data    (in_data),
		.in_valid   (in_valid),
		.in_read    (in_read),
		.cfg        (cfg),
		.sort_rd    (bank_rd),
		.bank_req   (bank_req),
		.sort_start (sort_start),
		.sort_done  (sort_done),
		.out_start  (out_start),
		.out_done   (out_done),
		.out_phase  (out_phase)
	);

	sort_engine u_sort_engine (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.sort_start (sort_start),
		.bank_rd    (bank_rd),
		.bank0_q    (bank0_q),
		.bank1_q    (bank1_q),
		.sort_req   (sort_wr),
		.sort_done  (sort_done)
	);

	stream_out u_stream_out (
		.clk       (clk),
		.reset     (reset),
		.out_start (out_start),
		.cfg       (cfg),
		.sort_rd   (out_rd),
		.sort_q    (sort_q),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_done  (out_done)
	);

	// ====================
	// memories
	// ====================
	assign sort_mem_req = out_phase ? out_rd : sort_wr; // one owner per phase

	sram_bytewise #(.DEPTH(`CVTOR_BANK_WORDS)) bank0 (
		.clk (clk),
		.req (bank_req[0]),
		.q   (bank0_q)
	);

	sram_bytewise #(.DEPTH(`CVTOR_BANK_WORDS)) bank1 (
		.clk (clk),
		.req (bank_req[1]),
		.q   (bank1_q)
	);

	sram_bytewise #(.DEPTH(`CVTOR_SORT_WORDS)) sort_mem (
		.clk (clk),
		.req (sort_mem_req),
		.q   (sort_q)
	);

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 100, // ns
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// held over whole cycles, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/tb_cvtor.sv
`timescale 1ns/10ps
`default_nettype none

`include "cvtor_settings.svh"

module tb_cvtor import cvtor_pkg::*; ();

	localparam int PERIOD = 100; // ns
	localparam int BANK = `CVTOR_BANK_WORDS;
	localparam int NB = `CVTOR_WORD_BYTES;
	localparam int FRAMES = 3; // two parts, one part, then the first again with gaps
	localparam logic [31:0] SEED = 32'hdd57553f;

	logic        clk;
	logic        reset;
	word_t       in_data;
	logic        in_valid;
	logic        in_read;
	stream_t     out_beat;
	logic        out_valid;
	word_t       bank_model [2][BANK]; // words as the banks hold them
	logic [31:0] gap_rng;
	int          cur_frame;
	bit          frame_active; // cleared by the checker on beat N
	int          beat_cnt;
	int          total_beats;

	tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(10)) u_clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	cvtor_top DUT (
		.clk       (clk),
		.reset     (reset),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_read   (in_read),
		.out_beat  (out_beat),
		.out_valid (out_valid)
	);

	// ====================
	// reference model
	// ====================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t reverse_word(input word_t w);
		word_t r;
		for (int i = 0; i < NB; i++) begin
			r[8*i +: 8] = w[8*(NB-1-i) +: 8];
		end
		return r;
	endfunction

	// stream side byte order
	function automatic word_t stream_order(input word_t w);
		return (`CVTOR_ENDIAN_SWAP != 0) ? reverse_word(w) : w;
	endfunction

	function automatic cfg_t frame_cfg_of(input int f);
		cfg_t c;
		c.ch_step = (f == 1) ? 16'd7 : 16'd4;
		c.chpart_step = (f == 1) ? 16'd9 : 16'd32;
		c.ch_part_num = (f == 1) ? 8'd1 : 8'd2;
		return c;
	endfunction

	// parts x 2 banks x 8 bytes x col parts
	function automatic int beats_of(input cfg_t c);
		return int'(c.ch_part_num) * 2 * NB * `CVTOR_COL_PARTS;
	endfunction

	function automatic word_t cfg_word(input cfg_t c);
		return stream_order({24'ha5a5a5, c.ch_part_num, c.chpart_step, c.ch_step}); // top ignored
	endfunction

	// w = p fastest, then b, t, c; lane k from k*ch_step + p*chpart_step + c
	function automatic word_t expected_beat(input cfg_t c, input int w);
		int    pn;
		int    p;
		int    b;
		int    t;
		int    cp;
		int    addr;
		word_t r;
		pn = int'(c.ch_part_num);
		p = w % pn;
		b = (w / pn) % 2;
		t = (w / (2 * pn)) % NB;
		cp = w / (2 * pn * NB);
		for (int k = 0; k < NB; k++) begin
			addr = (k * int'(c.ch_step) + p * int'(c.chpart_step) + cp) % BANK;
			r[8*(NB-1-k) +: 8] = bank_model[b][addr][8*(NB-1-t) +: 8]; // byte 0 is MSB
		end
		return stream_order(r);
	endfunction

	task automatic fill_banks(input logic [31:0] seed);
		logic [31:0] x;
		logic [31:0] y;
		x = seed;
		for (int b = 0; b < 2; b++) begin
			for (int a = 0; a < BANK; a++) begin
				x = xorshift32(x);
				y = xorshift32(x);
				bank_model[b][a] = {x, y};
				x = y;
			end
		end
	endtask

	// ====================
	// checks
	// ====================
	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic check_last(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s last expected %b actual %b", name, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// ====================
	// stimulus
	// ====================
	// retries each cycle until the word is taken
	task automatic send_word(input word_t w, input bit gaps);
		bit taken;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			gap_rng = xorshift32(gap_rng);
			in_valid = !(gaps && gap_rng[1:0] == 2'b00); // about one gap in four
			in_data = w;
			#(PERIOD / 4); // in_read settled well before the rising edge
			taken = in_valid && in_read;
		end
	endtask

	// source may keep offering the next config word through sort and output
	task automatic await_frame_end(input word_t hold_word, input bit hold);
		while (frame_active) begin
			@(negedge clk);
			in_valid = hold;
			in_data = hold_word;
			#(PERIOD / 4);
			if (in_read) begin
				report_failure("in_read went high while the frame was still sorted or streamed");
			end
		end
	endtask

	task automatic run_frame(input int f);
		cfg_t c;
		c = frame_cfg_of(f);
		fill_banks((f == 1) ? SEED ^ 32'h5a5a0000 : SEED ^ 32'h0000a5a5); // frame 2 reuses frame 0
		cur_frame = f;
		beat_cnt = 0;
		frame_active = 1'b1;
		send_word(cfg_word(c), f == 2);
		for (int i = 0; i < 2 * BANK; i++) begin
			send_word(stream_order(bank_model[i / BANK][i % BANK]), f == 2); // bank0 then bank1
		end
		await_frame_end(cfg_word(frame_cfg_of(f + 1)), f + 1 < FRAMES);
	endtask

	initial begin : stimulus
		int expected_total;
		in_valid = 1'b0;
		in_data = '0;
		gap_rng = SEED;
		cur_frame = 0;
		frame_active = 1'b0;
		beat_cnt = 0;
		total_beats = 0;
		expected_total = 0;
		@(negedge reset);
		repeat (20) begin // idle with no input
			@(negedge clk);
			if (in_read || out_valid || out_beat.last) begin
				report_failure("in_read, out_valid or last went high with no input after reset");
			end
		end
		for (int f = 0; f < FRAMES; f++) begin
			run_frame(f);
			expected_total += beats_of(frame_cfg_of(f));
		end
		in_valid = 1'b0;
		repeat (20) @(negedge clk); // stray beats would show here
		if (total_beats == expected_total) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("ERROR: %0d beats streamed, %0d expected", total_beats, expected_total);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	// ====================
	// beat checker
	// ====================
	initial begin : compare_beats
		cfg_t  c;
		string name;
		forever begin
			@(negedge clk);
			if (out_valid) begin
				c = frame_cfg_of(cur_frame);
				name = $sformatf("frame %0d beat %0d", cur_frame, beat_cnt);
				if (!frame_active || beat_cnt >= beats_of(c)) begin
					report_failure("out_valid went high outside the beats of a frame");
				end else begin
					check_word(name, expected_beat(c, beat_cnt), out_beat.data);
					check_last(name, beat_cnt == beats_of(c) - 1, out_beat.last);
					beat_cnt++;
					total_beats++;
					if (beat_cnt == beats_of(c)) frame_active = 1'b0;
				end
			end
		end
	end

	// per frame 200 + 256 store cycles + 10 per beat
	initial begin : watchdog
		int budget;
		budget = 10 + 20 + 20 + 10; // reset, idle, drain, margin
		for (int f = 0; f < FRAMES; f++) begin
			budget += 200 + 2 * 2 * BANK + 10 * beats_of(frame_cfg_of(f));
		end
		#(budget * PERIOD);
		$display("ERROR: timeout, the frames did not finish within %0d cycles", budget);
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- layout_cvtor.f
+incdir+hdl
hdl/cvtor_pkg.sv
hdl/sram_bytewise.sv
hdl/phase_ctrl.sv
hdl/sort_engine.sv
hdl/stream_out.sv
hdl/cvtor_top.sv
tb/tb_clock_gen.sv
tb/tb_cvtor.sv

//--- Bender.yml
package:
  name: layout_cvtor

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cvtor_pkg.sv
      - hdl/sram_bytewise.sv
      - hdl/phase_ctrl.sv
      - hdl/sort_engine.sv
      - hdl/stream_out.sv
      - hdl/cvtor_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_cvtor.sv
